// File: design/vmem_pkg.sv
package vmem_pkg;

   // AXI widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;
   localparam int LEN_W  = 8;

   // register file geometry
   localparam int V_LANES    = 4;
   localparam int NUM_VREGS  = 8;
   localparam int ELEMS      = 16;
   localparam int BANK_DEPTH = NUM_VREGS * ELEMS / V_LANES;

   // index widths
   localparam int VREG_W = $clog2(NUM_VREGS);
   localparam int ELEM_W = $clog2(ELEMS);
   localparam int VL_W   = ELEM_W + 1;

   // element e of vreg v sits in lane e mod V_LANES
   // at bank word v * ELEMS_PER_LANE + e / V_LANES
   localparam int LANE_W         = $clog2(V_LANES);
   localparam int BANK_AW        = $clog2(BANK_DEPTH);
   localparam int ELEMS_PER_LANE = ELEMS / V_LANES;

   typedef enum logic {
      VOP_LOAD  = 1'b0,
      VOP_STORE = 1'b1
   } vop_e;

   typedef enum logic [2:0] {
      S_IDLE  = 3'd0,
      S_ADDR  = 3'd1,
      S_RDATA = 3'd2,
      S_WDATA = 3'd3,
      S_WRESP = 3'd4,
      S_DONE  = 3'd5
   } vmem_state_e;

endpackage

// File: design/vrf_port_if.sv
`timescale 1ns/100ps

interface vrf_port_if;

   // write port
   logic                            we;
   logic [vmem_pkg::VREG_W-1:0]     wvreg;
   logic [vmem_pkg::ELEM_W-1:0]     welem;
   logic [vmem_pkg::DATA_W-1:0]     wdata;

   // read port with data following the address combinationally
   logic [vmem_pkg::VREG_W-1:0]     rvreg;
   logic [vmem_pkg::ELEM_W-1:0]     relem;
   logic [vmem_pkg::DATA_W-1:0]     rdata;

   modport ctrl (
      output we, wvreg, welem, wdata,
      output rvreg, relem,
      input  rdata
   );

   modport rf (
      input  we, wvreg, welem, wdata,
      input  rvreg, relem,
      output rdata
   );

endinterface

// File: design/elem_counter.sv
`timescale 1ns/100ps

module elem_counter (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clear,
   input  logic                          step,
   input  logic [vmem_pkg::VL_W-1:0]     vl,
   output logic [vmem_pkg::ELEM_W-1:0]   count,
   output logic                          last
);

   logic [vmem_pkg::VL_W-1:0] vl_q;
   logic [vmem_pkg::VL_W-1:0] last_idx;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         count <= '0;
         vl_q  <= '0;
      end
      else if (clear)
      begin
         // new burst captures its length
         count <= '0;
         vl_q  <= vl;
      end
      else if (step)
      begin
         count <= count + 1'b1;
      end
   end

   // index of the final element
   assign last_idx = vl_q - 1'b1;

   assign last = ({1'b0, count} == last_idx);

endmodule

// File: design/vector_regfile.sv
`timescale 1ns/100ps

module vector_regfile (
   input logic      clk,
   vrf_port_if.rf   vrf
);

   logic [vmem_pkg::LANE_W-1:0]  w_lane;
   logic [vmem_pkg::LANE_W-1:0]  r_lane;
   logic [vmem_pkg::BANK_AW-1:0] w_addr;
   logic [vmem_pkg::BANK_AW-1:0] r_addr;
   logic [vmem_pkg::DATA_W-1:0]  lane_rdata [vmem_pkg::V_LANES];

   // word index inside a lane bank
   function automatic logic [vmem_pkg::BANK_AW-1:0] bank_addr(
      input logic [vmem_pkg::VREG_W-1:0] vreg,
      input logic [vmem_pkg::ELEM_W-1:0] elem
   );
      logic [vmem_pkg::BANK_AW-1:0] base;
      logic [vmem_pkg::BANK_AW-1:0] offs;
      base = vmem_pkg::BANK_AW'(vreg) * vmem_pkg::BANK_AW'(vmem_pkg::ELEMS_PER_LANE);
      offs = vmem_pkg::BANK_AW'(elem / vmem_pkg::V_LANES);
      return base + offs;
   endfunction

   // lane is element modulo lane count
   assign w_lane = vrf.welem[vmem_pkg::LANE_W-1:0];
   assign r_lane = vrf.relem[vmem_pkg::LANE_W-1:0];

   assign w_addr = bank_addr(vrf.wvreg, vrf.welem);
   assign r_addr = bank_addr(vrf.rvreg, vrf.relem);

   for (genvar l = 0; l < vmem_pkg::V_LANES; l++)
   begin : g_lane
      logic [vmem_pkg::DATA_W-1:0] mem [vmem_pkg::BANK_DEPTH];

      always_ff @(posedge clk)
      begin
         if (vrf.we && (w_lane == l))
         begin
            mem[w_addr] <= vrf.wdata;
         end
      end

      // every bank reads the same word and the lane select picks one
      assign lane_rdata[l] = mem[r_addr];
   end

   assign vrf.rdata = lane_rdata[r_lane];

endmodule

// File: design/vmem_ctrl_fsm.sv
`timescale 1ns/100ps

module vmem_ctrl_fsm (
   input  logic                            clk,
   input  logic                            rst,
   // instruction side
   input  logic                            instr_start,
   input  vmem_pkg::vop_e                  instr_op,
   input  logic [vmem_pkg::VREG_W-1:0]     instr_vreg,
   input  logic [vmem_pkg::ADDR_W-1:0]     instr_addr,
   input  logic [vmem_pkg::VL_W-1:0]       instr_vl,
   output logic                            busy,
   output logic                            done,
   // AXI write channels
   output logic                            awvalid,
   output logic [vmem_pkg::ADDR_W-1:0]     awaddr,
   output logic [vmem_pkg::LEN_W-1:0]      awlen,
   input  logic                            awready,
   output logic                            wvalid,
   output logic [vmem_pkg::STRB_W-1:0]     wstrb,
   output logic                            wlast,
   input  logic                            wready,
   input  logic                            bvalid,
   output logic                            bready,
   // AXI read channels
   output logic                            arvalid,
   output logic [vmem_pkg::ADDR_W-1:0]     araddr,
   output logic [vmem_pkg::LEN_W-1:0]      arlen,
   input  logic                            arready,
   input  logic                            rvalid,
   input  logic [vmem_pkg::DATA_W-1:0]     rdata,
   input  logic                            rlast,
   output logic                            rready,
   // element counter
   output logic                            clear,
   output logic                            step,
   input  logic [vmem_pkg::ELEM_W-1:0]     count,
   input  logic                            last,
   // register file
   vrf_port_if.ctrl                        vrf
);

   vmem_pkg::vmem_state_e            state_q;
   vmem_pkg::vmem_state_e            state_d;
   vmem_pkg::vop_e                   op_q;
   logic [vmem_pkg::VREG_W-1:0]      vreg_q;
   logic [vmem_pkg::ADDR_W-1:0]      addr_q;
   logic [vmem_pkg::VL_W-1:0]        len_m1;
   logic [vmem_pkg::LEN_W-1:0]       len_q;
   logic                             is_load;
   logic                             rd_beat;
   logic                             wr_beat;

   assign is_load = (op_q == vmem_pkg::VOP_LOAD);
   assign rd_beat = (state_q == vmem_pkg::S_RDATA) && rvalid;
   assign wr_beat = (state_q == vmem_pkg::S_WDATA) && wready;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         vmem_pkg::S_IDLE:
            if (instr_start) state_d = vmem_pkg::S_ADDR;
         vmem_pkg::S_ADDR:
            if (is_load && arready) state_d = vmem_pkg::S_RDATA;
            else if (!is_load && awready) state_d = vmem_pkg::S_WDATA;
         vmem_pkg::S_RDATA:
            if (rd_beat && (last || rlast)) state_d = vmem_pkg::S_DONE;
         vmem_pkg::S_WDATA:
            if (wr_beat && last) state_d = vmem_pkg::S_WRESP;
         vmem_pkg::S_WRESP:
            if (bvalid) state_d = vmem_pkg::S_DONE;
         vmem_pkg::S_DONE:
            state_d = vmem_pkg::S_IDLE;
         default:
            state_d = vmem_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q <= vmem_pkg::S_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // burst length is vl minus one
   assign len_m1 = instr_vl - 1'b1;

   // instruction fields held for the whole burst
   always_ff @(posedge clk)
   begin
      if ((state_q == vmem_pkg::S_IDLE) && instr_start)
      begin
         op_q   <= instr_op;
         vreg_q <= instr_vreg;
         addr_q <= instr_addr;
         len_q  <= vmem_pkg::LEN_W'(len_m1);
      end
   end

   assign busy = (state_q != vmem_pkg::S_IDLE);
   assign done = (state_q == vmem_pkg::S_DONE);

   // address phase
   assign arvalid = (state_q == vmem_pkg::S_ADDR) && is_load;
   assign awvalid = (state_q == vmem_pkg::S_ADDR) && !is_load;
   assign araddr  = addr_q;
   assign awaddr  = addr_q;
   assign arlen   = len_q;
   assign awlen   = len_q;

   // data and response phases
   assign rready = (state_q == vmem_pkg::S_RDATA);
   assign wvalid = (state_q == vmem_pkg::S_WDATA);
   assign wstrb  = '1;
   assign wlast  = last;
   assign bready = (state_q == vmem_pkg::S_WRESP);

   // counter control
   assign clear = (state_q == vmem_pkg::S_IDLE) && instr_start;
   assign step  = rd_beat || wr_beat;

   // load beats land in the register file
   assign vrf.we    = rd_beat;
   assign vrf.wvreg = vreg_q;
   assign vrf.welem = count;
   assign vrf.wdata = rdata;

   // store data comes straight from the read port
   assign vrf.rvreg = vreg_q;
   assign vrf.relem = count;

endmodule

// File: design/vmem_subsystem.sv
`timescale 1ns/100ps

module vmem_subsystem (
   input  logic                            clk,
   input  logic                            rst,
   // instruction side
   input  logic                            instr_start,
   input  vmem_pkg::vop_e                  instr_op,
   input  logic [vmem_pkg::VREG_W-1:0]     instr_vreg,
   input  logic [vmem_pkg::ADDR_W-1:0]     instr_addr,
   input  logic [vmem_pkg::VL_W-1:0]       instr_vl,
   output logic                            busy,
   output logic                            done,
   // AXI4 master write address and data
   output logic                            awvalid,
   output logic [vmem_pkg::ADDR_W-1:0]     awaddr,
   output logic [vmem_pkg::LEN_W-1:0]      awlen,
   input  logic                            awready,
   output logic                            wvalid,
   output logic [vmem_pkg::DATA_W-1:0]     wdata,
   output logic [vmem_pkg::STRB_W-1:0]     wstrb,
   output logic                            wlast,
   input  logic                            wready,
   // write response
   input  logic                            bvalid,
   output logic                            bready,
   // read address and data
   output logic                            arvalid,
   output logic [vmem_pkg::ADDR_W-1:0]     araddr,
   output logic [vmem_pkg::LEN_W-1:0]      arlen,
   input  logic                            arready,
   input  logic                            rvalid,
   input  logic [vmem_pkg::DATA_W-1:0]     rdata,
   input  logic                            rlast,
   output logic                            rready
);

   logic                          cnt_clear;
   logic                          cnt_step;
   logic [vmem_pkg::ELEM_W-1:0]   cnt_count;
   logic                          cnt_last;

   vrf_port_if vrf_bus ();

   vmem_ctrl_fsm vmem_ctrl_fsm_i (
      .clk         (clk),
      .rst         (rst),
      .instr_start (instr_start),
      .instr_op    (instr_op),
      .instr_vreg  (instr_vreg),
      .instr_addr  (instr_addr),
      .instr_vl    (instr_vl),
      .busy        (busy),
      .done        (done),
      .awvalid     (awvalid),
      .awaddr      (awaddr),
      .awlen       (awlen),
      .awready     (awready),
      .wvalid      (wvalid),
      .wstrb       (wstrb),
      .wlast       (wlast),
      .wready      (wready),
      .bvalid      (bvalid),
      .bready      (bready),
      .arvalid     (arvalid),
      .araddr      (araddr),
      .arlen       (arlen),
      .arready     (arready),
      .rvalid      (rvalid),
      .rdata       (rdata),
      .rlast       (rlast),
      .rready      (rready),
      .clear       (cnt_clear),
      .step        (cnt_step),
      .count       (cnt_count),
      .last        (cnt_last),
      .vrf         (vrf_bus.ctrl)
   );

   elem_counter elem_counter_i (
      .clk   (clk),
      .rst   (rst),
      .clear (cnt_clear),
      .step  (cnt_step),
      .vl    (instr_vl),
      .count (cnt_count),
      .last  (cnt_last)
   );

   vector_regfile vector_regfile_i (
      .clk (clk),
      .vrf (vrf_bus.rf)
   );

   // store data leaves straight from the register file read port
   assign wdata = vrf_bus.rdata;

endmodule

// File: dv/axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model (
   input  logic                            clk,
   input  logic                            rst,
   // write address and data
   input  logic                            awvalid,
   input  logic [vmem_pkg::ADDR_W-1:0]     awaddr,
   input  logic [vmem_pkg::LEN_W-1:0]      awlen,
   output logic                            awready,
   input  logic                            wvalid,
   input  logic [vmem_pkg::DATA_W-1:0]     wdata,
   input  logic [vmem_pkg::STRB_W-1:0]     wstrb,
   input  logic                            wlast,
   output logic                            wready,
   output logic                            bvalid,
   input  logic                            bready,
   // read address and data
   input  logic                            arvalid,
   input  logic [vmem_pkg::ADDR_W-1:0]     araddr,
   input  logic [vmem_pkg::LEN_W-1:0]      arlen,
   output logic                            arready,
   output logic                            rvalid,
   output logic [vmem_pkg::DATA_W-1:0]     rdata,
   output logic                            rlast,
   input  logic                            rready
);

   // 256 words indexed by address bits 9:2
   logic [vmem_pkg::DATA_W-1:0]  mem [256];

   integer                       seed = 53;
   logic [31:0]                  rnd;
   logic                         rd_active;
   logic                         wr_active;
   logic [7:0]                   rd_base;
   logic [7:0]                   rd_cnt;
   logic [7:0]                   wr_base;
   logic [7:0]                   wr_cnt;
   logic [vmem_pkg::LEN_W-1:0]   rd_len;
   logic [vmem_pkg::LEN_W-1:0]   wr_len;

   // observation counters for the testbench
   logic [vmem_pkg::DATA_W-1:0]  ar_bursts;
   logic [vmem_pkg::DATA_W-1:0]  aw_bursts;
   logic [vmem_pkg::DATA_W-1:0]  proto_errs;
   logic [vmem_pkg::LEN_W-1:0]   last_arlen;
   logic [vmem_pkg::LEN_W-1:0]   last_awlen;

   assign rdata = mem[rd_base + rd_cnt];
   assign rlast = (rd_cnt == rd_len);

   always @(posedge clk)
   begin
      rnd = $random(seed);
      if (rst)
      begin
         arready    <= 1'b0;
         awready    <= 1'b0;
         wready     <= 1'b0;
         rvalid     <= 1'b0;
         bvalid     <= 1'b0;
         rd_active  <= 1'b0;
         wr_active  <= 1'b0;
         rd_cnt     <= '0;
         wr_cnt     <= '0;
         ar_bursts  <= '0;
         aw_bursts  <= '0;
         proto_errs <= '0;
         last_arlen <= '0;
         last_awlen <= '0;
      end
      else
      begin
         // random stalls on roughly one cycle in four
         arready <= rnd[0] || rnd[1];
         awready <= rnd[4] || rnd[5];
         wready  <= wr_active && (rnd[6] || rnd[7]);

         if (arvalid && arready && !rd_active)
         begin
            rd_active  <= 1'b1;
            rd_base    <= araddr[9:2];
            rd_len     <= arlen;
            rd_cnt     <= '0;
            ar_bursts  <= ar_bursts + 1'b1;
            last_arlen <= arlen;
         end

         // rvalid stays up until taken
         if (rvalid && rready)
         begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rlast)
            begin
               rd_active <= 1'b0;
               rvalid    <= 1'b0;
            end
            else
            begin
               rvalid <= rnd[2] || rnd[3];
            end
         end
         else if (rd_active && !rvalid)
         begin
            rvalid <= rnd[2] || rnd[3];
         end

         if (awvalid && awready && !wr_active)
         begin
            wr_active  <= 1'b1;
            wr_base    <= awaddr[9:2];
            wr_len     <= awlen;
            wr_cnt     <= '0;
            aw_bursts  <= aw_bursts + 1'b1;
            last_awlen <= awlen;
         end

         if (bvalid && bready)
         begin
            bvalid <= 1'b0;
         end

         if (wvalid && wready && wr_active)
         begin
            mem[wr_base + wr_cnt] <= wdata;
            // wlast marks exactly the final beat and all strobes are set
            if ((wlast != (wr_cnt == wr_len)) || (wstrb != '1))
            begin
               proto_errs <= proto_errs + 1'b1;
            end
            wr_cnt <= wr_cnt + 1'b1;
            if (wlast)
            begin
               wr_active <= 1'b0;
               bvalid    <= 1'b1;
            end
         end
      end
   end

endmodule

// File: dv/vmem_tb.sv
`timescale 1ns/100ps

module vmem_tb;

   logic                            clk;
   logic                            rst;
   logic                            instr_start;
   vmem_pkg::vop_e                  instr_op;
   logic [vmem_pkg::VREG_W-1:0]     instr_vreg;
   logic [vmem_pkg::ADDR_W-1:0]     instr_addr;
   logic [vmem_pkg::VL_W-1:0]       instr_vl;
   logic                            busy;
   logic                            done;
   logic                            awvalid;
   logic                            awready;
   logic                            wvalid;
   logic                            wlast;
   logic                            wready;
   logic                            bvalid;
   logic                            bready;
   logic                            arvalid;
   logic                            arready;
   logic                            rvalid;
   logic                            rlast;
   logic                            rready;
   logic [vmem_pkg::ADDR_W-1:0]     awaddr;
   logic [vmem_pkg::ADDR_W-1:0]     araddr;
   logic [vmem_pkg::LEN_W-1:0]      awlen;
   logic [vmem_pkg::LEN_W-1:0]      arlen;
   logic [vmem_pkg::DATA_W-1:0]     wdata;
   logic [vmem_pkg::DATA_W-1:0]     rdata;
   logic [vmem_pkg::STRB_W-1:0]     wstrb;

   // stimulus table with src as the word index the stored data came from
   vmem_pkg::vop_e                  tbl_op   [8];
   logic [vmem_pkg::VREG_W-1:0]     tbl_vreg [8];
   logic [vmem_pkg::ADDR_W-1:0]     tbl_addr [8];
   logic [vmem_pkg::VL_W-1:0]       tbl_vl   [8];
   int                              tbl_src  [8];

   logic [vmem_pkg::DATA_W-1:0]     done_count = '0;
   int                              errors;
   int                              tests;
   int                              failed;
   int                              exp_ar;
   int                              exp_aw;
   logic                            timed_out;

   vmem_subsystem vmem_subsystem_i (.*);

   axi_mem_model mem_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(negedge clk)
   begin
      if (!rst && done === 1'b1)
      begin
         done_count <= done_count + 1'b1;
      end
   end

   function automatic logic [vmem_pkg::DATA_W-1:0] src_pattern(input int word);
      return vmem_pkg::DATA_W'(word * 3 + 'h1000);
   endfunction

   task automatic check_word(input string name, input logic [vmem_pkg::DATA_W-1:0] got,
                             input logic [vmem_pkg::DATA_W-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_state(input string name, input logic [vmem_pkg::LEN_W-1:0] got,
                              input logic [vmem_pkg::LEN_W-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic set_row(input int r, input vmem_pkg::vop_e op, input int vreg,
                          input int addr, input int vl, input int src);
      tbl_op[r]   = op;
      tbl_vreg[r] = vmem_pkg::VREG_W'(vreg);
      tbl_addr[r] = vmem_pkg::ADDR_W'(addr);
      tbl_vl[r]   = vmem_pkg::VL_W'(vl);
      tbl_src[r]  = src;
   endtask

   task automatic fill_table();
      set_row(0, vmem_pkg::VOP_LOAD,  2, 'h000, 16, 0);
      set_row(1, vmem_pkg::VOP_STORE, 2, 'h200, 16, 0);
      // partial vector
      set_row(2, vmem_pkg::VOP_LOAD,  3, 'h040, 5, 0);
      set_row(3, vmem_pkg::VOP_STORE, 3, 'h280, 5, 16);
      // two vregs live at once
      set_row(4, vmem_pkg::VOP_LOAD,  1, 'h100, 16, 0);
      set_row(5, vmem_pkg::VOP_LOAD,  6, 'h180, 16, 0);
      set_row(6, vmem_pkg::VOP_STORE, 1, 'h300, 16, 64);
      set_row(7, vmem_pkg::VOP_STORE, 6, 'h3c0, 16, 96);
   endtask

   task automatic check_reset_values();
      check_flag("busy", busy, 1'b0);
      check_flag("done", done, 1'b0);
      check_flag("arvalid", arvalid, 1'b0);
      check_flag("awvalid", awvalid, 1'b0);
      check_flag("wvalid", wvalid, 1'b0);
      check_flag("rready", rready, 1'b0);
      check_flag("bready", bready, 1'b0);
      tests++;
      if (errors != 0)
      begin
         failed++;
      end
      $display("test reset values: %s", (errors == 0) ? "ok" : "errors");
   endtask

   task automatic wait_done(input int r);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (done !== 1'b1 && cycles < 2000)
      begin
         @(negedge clk);
         cycles++;
      end
      if (done !== 1'b1)
      begin
         timed_out = 1'b1;
         $display("timeout: test %0d never signalled done", r);
      end
   endtask

   task automatic run_row(input int r);
      int errs_before;
      int base;
      int dst;
      logic [vmem_pkg::DATA_W-1:0] exp;
      errs_before = errors;
      @(posedge clk);
      instr_start <= 1'b1;
      instr_op    <= tbl_op[r];
      instr_vreg  <= tbl_vreg[r];
      instr_addr  <= tbl_addr[r];
      instr_vl    <= tbl_vl[r];
      @(posedge clk);
      instr_start <= 1'b0;
      @(negedge clk);
      check_flag("busy", busy, 1'b1);
      // address phase opens right after the start
      if (tbl_op[r] == vmem_pkg::VOP_LOAD)
         check_flag("arvalid", arvalid, 1'b1);
      else
         check_flag("awvalid", awvalid, 1'b1);
      // a start while busy has to be dropped
      @(posedge clk);
      instr_start <= 1'b1;
      @(posedge clk);
      instr_start <= 1'b0;
      wait_done(r);
      if (!timed_out)
      begin
         @(negedge clk);
         check_flag("done", done, 1'b0);
         check_flag("busy", busy, 1'b0);
         check_word("done_count", done_count, vmem_pkg::DATA_W'(r + 1));
         check_word("proto_errs", mem_i.proto_errs, '0);
         if (tbl_op[r] == vmem_pkg::VOP_LOAD)
         begin
            exp_ar++;
            check_state("arlen", mem_i.last_arlen, vmem_pkg::LEN_W'(tbl_vl[r] - 1));
         end
         else
         begin
            exp_aw++;
            check_state("awlen", mem_i.last_awlen, vmem_pkg::LEN_W'(tbl_vl[r] - 1));
            base = int'(tbl_addr[r] >> 2);
            // words past vl keep their preloaded value
            for (int k = 0; k < vmem_pkg::ELEMS; k++)
            begin
               dst = base + k;
               if (k < int'(tbl_vl[r]))
                  exp = src_pattern(tbl_src[r] + k);
               else
                  exp = src_pattern(dst);
               check_word($sformatf("mem[%0d]", dst), mem_i.mem[8'(dst)], exp);
            end
         end
         check_word("ar_bursts", mem_i.ar_bursts, vmem_pkg::DATA_W'(exp_ar));
         check_word("aw_bursts", mem_i.aw_bursts, vmem_pkg::DATA_W'(exp_aw));
      end
      tests++;
      if (errors != errs_before || timed_out)
      begin
         failed++;
      end
      $display("test %0d %s vreg %0d vl %0d: %s", r, tbl_op[r].name(), tbl_vreg[r],
               tbl_vl[r], (errors != errs_before || timed_out) ? "errors" : "ok");
   endtask

   initial
   begin
      instr_start = 1'b0;
      instr_op    = vmem_pkg::VOP_LOAD;
      instr_vreg  = '0;
      instr_addr  = '0;
      instr_vl    = '0;
      rst         = 1'b1;
      errors      = 0;
      tests       = 0;
      failed      = 0;
      exp_ar      = 0;
      exp_aw      = 0;
      timed_out   = 1'b0;
      fill_table();
      for (int i = 0; i < 256; i++)
      begin
         mem_i.mem[i] = src_pattern(i);
      end
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_reset_values();
      for (int r = 0; r < $size(tbl_op) && !timed_out; r++)
      begin
         run_row(r);
      end
      $display("tests run %0d, tests failed %0d, check errors %0d", tests, failed, errors);
      if (errors == 0 && !timed_out)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: list.f
design/vmem_pkg.sv
design/vrf_port_if.sv
design/elem_counter.sv
design/vector_regfile.sv
design/vmem_ctrl_fsm.sv
design/vmem_subsystem.sv
dv/axi_mem_model.sv
dv/vmem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the vmem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module vmem_tb -f list.f -o vmem_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/vmem_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

echo "$out" | grep -q "^STATUS: PASS$" || exit 1
exit 0
